// File: arcade_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_consts.svh"

module arcade_cfg_regs (
	input  logic                  clock_12,
	input  logic                  reset,
	input  arcade_pkg::axil_req_t axil_req,
	output arcade_pkg::axil_rsp_t axil_rsp,
	output arcade_pkg::cfg_t      cfg,
	input  logic                  rom_loaded,
	input  logic [12:0]           dl_count
);

	arcade_pkg::axil_state_e wr_state;
	arcade_pkg::axil_state_e rd_state;
	logic                    wr_accept;
	logic                    rd_accept;
	logic [31:0]             rd_mux;
	logic [31:0]             rdata_q;

	// address and data must arrive together.
	assign wr_accept = (wr_state == arcade_pkg::IDLE) && axil_req.awvalid && axil_req.wvalid;
	assign rd_accept = (rd_state == arcade_pkg::IDLE) && axil_req.arvalid;

	always_ff @(posedge clock_12) begin
		if (reset) begin
			wr_state <= arcade_pkg::IDLE;
			cfg      <= '0;
		end else begin
			case (wr_state)
				arcade_pkg::IDLE: begin
					if (wr_accept) begin
						wr_state <= arcade_pkg::RESP;
						if (axil_req.awaddr == `ARC_REG_CTRL) begin
							cfg.soft_reset <= axil_req.wdata[0];
							cfg.rotate     <= axil_req.wdata[1];
							cfg.scanlines  <= arcade_pkg::scan_level_e'(axil_req.wdata[3:2]);
						end
					end
				end
				arcade_pkg::RESP: begin
					if (axil_req.bready) wr_state <= arcade_pkg::IDLE;
				end
				default: wr_state <= arcade_pkg::IDLE;
			endcase
		end
	end

	always_comb begin
		case (axil_req.araddr)
			`ARC_REG_CTRL:   rd_mux = {28'd0, cfg.scanlines, cfg.rotate, cfg.soft_reset};
			`ARC_REG_STATUS: rd_mux = {31'd0, rom_loaded};
			`ARC_REG_COUNT:  rd_mux = {19'd0, dl_count};
			default:         rd_mux = 32'd0; // holes in the map read as zero.
		endcase
	end

	always_ff @(posedge clock_12) begin
		if (reset) begin
			rd_state <= arcade_pkg::IDLE;
		end else begin
			case (rd_state)
				arcade_pkg::IDLE: if (rd_accept) rd_state <= arcade_pkg::RESP;
				arcade_pkg::RESP: if (axil_req.rready) rd_state <= arcade_pkg::IDLE;
				default:          rd_state <= arcade_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_12) begin
		if (rd_accept) rdata_q <= rd_mux; // held until the host takes it.
	end

	always_comb begin
		axil_rsp         = '0;
		axil_rsp.awready = wr_accept;
		axil_rsp.wready  = wr_accept;
		axil_rsp.bvalid  = (wr_state == arcade_pkg::RESP);
		axil_rsp.bresp   = 2'b00;
		axil_rsp.arready = rd_accept;
		axil_rsp.rvalid  = (rd_state == arcade_pkg::RESP);
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = 2'b00;
	end

endmodule

`default_nettype wire

// File: arcade_consts.svh
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// on-chip ROM buffer that stands in for the SDRAM.
`define ARC_ROM_DEPTH 4096
`define ARC_ROM_AW    12

// AXI4-Lite register byte offsets.
`define ARC_REG_CTRL   4'h0
`define ARC_REG_STATUS 4'h4
`define ARC_REG_COUNT  4'h8

// PS/2 set 2 scan codes for player one.
`define ARC_KEY_UP    8'h75
`define ARC_KEY_DOWN  8'h72
`define ARC_KEY_LEFT  8'h6b
`define ARC_KEY_RIGHT 8'h74
`define ARC_KEY_FIRE  8'h29 // space bar.
`define ARC_KEY_COIN  8'h2e // key 5.
`define ARC_KEY_START 8'h16 // key 1.

`endif

// File: arcade_inputs.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_consts.svh"

module arcade_inputs (
	input  logic                     clock_12,
	input  logic                     reset,
	input  arcade_pkg::cfg_t         cfg,
	input  arcade_pkg::key_event_t   key,
	input  logic [7:0]               joystick,
	output arcade_pkg::player_ctrl_t ctrl
);

	arcade_pkg::player_ctrl_t key_state;
	arcade_pkg::player_ctrl_t key_next;
	arcade_pkg::player_ctrl_t merged;
	arcade_pkg::player_ctrl_t rotated;

	always_comb begin
		key_next = key_state;
		if (key.strobe) begin
			case (key.code)
				`ARC_KEY_UP:    key_next.up    = key.pressed;
				`ARC_KEY_DOWN:  key_next.down  = key.pressed;
				`ARC_KEY_LEFT:  key_next.left  = key.pressed;
				`ARC_KEY_RIGHT: key_next.right = key.pressed;
				`ARC_KEY_FIRE:  key_next.fire  = key.pressed;
				`ARC_KEY_COIN:  key_next.coin  = key.pressed;
				`ARC_KEY_START: key_next.start = key.pressed;
				default: ; // other keys belong to nobody.
			endcase
		end
	end

	always_comb begin
		merged.up    = key_next.up    | joystick[0];
		merged.down  = key_next.down  | joystick[1];
		merged.left  = key_next.left  | joystick[2];
		merged.right = key_next.right | joystick[3];
		merged.fire  = key_next.fire  | joystick[4];
		merged.coin  = key_next.coin  | joystick[5];
		merged.start = key_next.start | joystick[6];
		rotated = merged;
		if (cfg.rotate) begin
			rotated.up    = merged.right; // quarter turn for a monitor on its side.
			rotated.right = merged.down;
			rotated.down  = merged.left;
			rotated.left  = merged.up;
		end
	end

	always_ff @(posedge clock_12) begin
		if (reset) begin
			key_state <= '0;
			ctrl      <= '0;
		end else begin
			key_state <= key_next;
			ctrl      <= rotated;
		end
	end

endmodule

`default_nettype wire

// File: arcade_pkg.sv
`default_nettype none

`include "arcade_consts.svh"

package arcade_pkg;

	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scan_level_e;

	typedef enum logic {
		IDLE = 1'b0,
		RESP = 1'b1
	} axil_state_e;

	typedef struct packed {
		logic        awvalid;
		logic [3:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic        bready;
		logic        arvalid;
		logic [3:0]  araddr;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic        soft_reset;
		logic        rotate;
		scan_level_e scanlines;
	} cfg_t;

	typedef struct packed {
		logic                   active;
		logic                   wr;
		logic [`ARC_ROM_AW-1:0] addr;
		logic [7:0]             data;
	} rom_dl_t;

	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic coin;
		logic start;
	} player_ctrl_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hs;
		logic       vs;
		logic       blankn;
	} pixel_in_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_out_t;

endpackage

`default_nettype wire

// File: arcade_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_consts.svh"

module arcade_top (
	input  logic                     clock_12,
	input  logic                     reset,
	input  arcade_pkg::axil_req_t    axil_req,
	output arcade_pkg::axil_rsp_t    axil_rsp,
	input  arcade_pkg::rom_dl_t      dl,
	input  arcade_pkg::key_event_t   key,
	input  logic [7:0]               joystick,
	input  arcade_pkg::pixel_in_t    pixel,
	input  logic [`ARC_ROM_AW-1:0]   rom_addr,
	output logic [7:0]               rom_data,
	output logic                     core_reset,
	output arcade_pkg::player_ctrl_t ctrl,
	output arcade_pkg::vga_out_t     vga
);

	arcade_pkg::cfg_t cfg;
	logic             rom_loaded;
	logic [12:0]      dl_count;

	arcade_cfg_regs i_cfg_regs (
		.clock_12   (clock_12),
		.reset      (reset),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.cfg        (cfg),
		.rom_loaded (rom_loaded),
		.dl_count   (dl_count)
	);

	rom_loader i_rom_loader (
		.clock_12   (clock_12),
		.reset      (reset),
		.cfg        (cfg),
		.dl         (dl),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_loaded (rom_loaded),
		.dl_count   (dl_count),
		.core_reset (core_reset)
	);

	arcade_inputs i_inputs (
		.clock_12 (clock_12),
		.reset    (reset),
		.cfg      (cfg),
		.key      (key),
		.joystick (joystick),
		.ctrl     (ctrl)
	);

	video_out i_video (
		.clock_12 (clock_12),
		.reset    (reset),
		.cfg      (cfg),
		.pixel    (pixel),
		.vga      (vga)
	);

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
arcade_pkg.sv
arcade_cfg_regs.sv
rom_loader.sv
arcade_inputs.sv
video_out.sv
arcade_top.sv
tb_arcade_top.sv

// File: rom_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_consts.svh"

module rom_loader (
	input  logic                   clock_12,
	input  logic                   reset,
	input  arcade_pkg::cfg_t       cfg,
	input  arcade_pkg::rom_dl_t    dl,
	input  logic [`ARC_ROM_AW-1:0] rom_addr,
	output logic [7:0]             rom_data,
	output logic                   rom_loaded,
	output logic [12:0]            dl_count,
	output logic                   core_reset
);

	logic [7:0] rom_mem [0:`ARC_ROM_DEPTH-1];
	logic       active_d;

	always_ff @(posedge clock_12) begin
		if (dl.active && dl.wr) rom_mem[dl.addr] <= dl.data;
		rom_data <= rom_mem[rom_addr];
	end

	always_ff @(posedge clock_12) begin
		if (reset) begin
			active_d   <= 1'b0;
			rom_loaded <= 1'b0;
			dl_count   <= 13'd0;
		end else begin
			active_d <= dl.active;
			if (active_d && !dl.active) rom_loaded <= 1'b1; // download just finished.
			if (dl.active && !active_d) begin
				dl_count <= {12'd0, dl.wr};
			end else if (dl.active && dl.wr) begin
				dl_count <= dl_count + 13'd1;
			end
		end
	end

	// The core sits in reset until the image is in place.
	always_ff @(posedge clock_12) begin
		core_reset <= reset || cfg.soft_reset || !rom_loaded;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_arcade_top -f flist.f -o sim_tb
out=$(./obj_dir/sim_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Everything OK"

// File: tb_arcade_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "arcade_consts.svh"

module tb_arcade_top;

	typedef enum logic [1:0] {
		OP_WR,
		OP_RD,
		OP_KEY,
		OP_JOY
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [3:0]  addr;
		logic [31:0] data;
		logic [3:0]  hold;
		logic [31:0] exp;
	} step_t;

	localparam logic [23:0] key_press   = 24'd1;
	localparam logic [23:0] key_release = 24'd0;

	logic                     clock_12 = 1'b0;
	logic                     reset;
	arcade_pkg::axil_req_t    axil_req;
	arcade_pkg::axil_rsp_t    axil_rsp;
	arcade_pkg::rom_dl_t      dl;
	arcade_pkg::key_event_t   key;
	logic [7:0]               joystick;
	arcade_pkg::pixel_in_t    pixel;
	logic [`ARC_ROM_AW-1:0]   rom_addr;
	logic [7:0]               rom_data;
	logic                     core_reset;
	arcade_pkg::player_ctrl_t ctrl;
	arcade_pkg::vga_out_t     vga;

	step_t                 steps [$];
	logic [31:0]           rnd;
	logic [7:0]            rom_byte [0:63];
	arcade_pkg::pixel_in_t pix [0:23];

	arcade_top i_dut (
		.clock_12   (clock_12),
		.reset      (reset),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.dl         (dl),
		.key        (key),
		.joystick   (joystick),
		.pixel      (pixel),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.core_reset (core_reset),
		.ctrl       (ctrl),
		.vga        (vga)
	);

	always #2 clock_12 = !clock_12;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("Something failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("Something failed");
		$fatal(1, "stopped on a timeout");
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic arcade_pkg::vga_out_t expected_vga(input arcade_pkg::pixel_in_t p,
			input logic odd, input arcade_pkg::scan_level_e lvl);
		arcade_pkg::vga_out_t v;
		logic [5:0]           c [0:2];
		logic [2:0]           b3;
		int                   k;
		b3   = {p.b, p.b[1]};
		c[0] = {p.r, p.r};
		c[1] = {p.g, p.g};
		c[2] = {b3, b3};
		for (k = 0; k < 3; k++) begin
			if (!p.blankn) c[k] = 6'd0;
			else if (odd && lvl == arcade_pkg::SCAN_25) c[k] = c[k] - (c[k] >> 2);
			else if (odd && lvl == arcade_pkg::SCAN_50) c[k] = c[k] >> 1;
			else if (odd && lvl == arcade_pkg::SCAN_75) c[k] = c[k] >> 2;
		end
		v.r  = c[0];
		v.g  = c[1];
		v.b  = c[2];
		v.hs = p.hs;
		v.vs = p.vs;
		return v;
	endfunction

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input int hold);
		int n;
		int i;
		@(posedge clock_12);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		n = 0;
		@(negedge clock_12);
		while (!axil_rsp.awready) begin
			n = n + 1;
			if (n > 20) report_timeout("awready");
			@(negedge clock_12);
		end
		check_value("wready", 32'(axil_rsp.wready), 32'd1);
		@(posedge clock_12);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		n = 0;
		@(negedge clock_12);
		while (!axil_rsp.bvalid) begin
			n = n + 1;
			if (n > 20) report_timeout("bvalid");
			@(negedge clock_12);
		end
		check_value("bresp", 32'(axil_rsp.bresp), 32'd0);
		for (i = 0; i < hold; i++) begin
			@(negedge clock_12);
			check_value("bvalid", 32'(axil_rsp.bvalid), 32'd1); // bready is still low.
		end
		@(posedge clock_12);
		axil_req.bready <= 1'b1;
		@(posedge clock_12);
		axil_req.bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, input int hold, output logic [31:0] data);
		int n;
		int i;
		@(posedge clock_12);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		n = 0;
		@(negedge clock_12);
		while (!axil_rsp.arready) begin
			n = n + 1;
			if (n > 20) report_timeout("arready");
			@(negedge clock_12);
		end
		@(posedge clock_12);
		axil_req.arvalid <= 1'b0;
		axil_req.araddr  <= addr ^ 4'h4; // the address moves on while the response waits.
		n = 0;
		@(negedge clock_12);
		while (!axil_rsp.rvalid) begin
			n = n + 1;
			if (n > 20) report_timeout("rvalid");
			@(negedge clock_12);
		end
		data = axil_rsp.rdata;
		check_value("rresp", 32'(axil_rsp.rresp), 32'd0);
		for (i = 0; i < hold; i++) begin
			@(negedge clock_12);
			check_value("rvalid", 32'(axil_rsp.rvalid), 32'd1);
			check_value("rdata", axil_rsp.rdata, data); // must not move while waiting.
		end
		@(posedge clock_12);
		axil_req.rready <= 1'b1;
		@(posedge clock_12);
		axil_req.rready <= 1'b0;
	endtask

	task automatic add_step(input op_e op, input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] hold, input logic [31:0] exp);
		step_t s;
		s = '{op, addr, data, hold, exp};
		steps.push_back(s);
	endtask

	// expected ctrl values are {up, down, left, right, fire, coin, start}.
	task automatic fill_steps();
		add_step(OP_WR, `ARC_REG_CTRL, 32'h0000_000e, 4'd3, 32'd0);
		add_step(OP_RD, `ARC_REG_CTRL, 32'd0, 4'd4, 32'h0000_000e);
		add_step(OP_RD, 4'hc, 32'd0, 4'd2, 32'd0);
		add_step(OP_WR, 4'hc, 32'hffff_ffff, 4'd0, 32'd0);
		add_step(OP_RD, `ARC_REG_CTRL, 32'd0, 4'd0, 32'h0000_000e);
		add_step(OP_WR, `ARC_REG_CTRL, 32'd0, 4'd0, 32'd0);
		add_step(OP_KEY, 4'd0, {key_press, `ARC_KEY_UP}, 4'd0, 32'b1000000);
		add_step(OP_KEY, 4'd0, {key_press, `ARC_KEY_FIRE}, 4'd0, 32'b1000100);
		add_step(OP_KEY, 4'd0, {key_press, 8'h1c}, 4'd0, 32'b1000100);
		add_step(OP_KEY, 4'd0, {key_release, `ARC_KEY_UP}, 4'd0, 32'b0000100);
		add_step(OP_JOY, 4'd0, 32'h08, 4'd0, 32'b0001100);
		add_step(OP_JOY, 4'd0, 32'h60, 4'd0, 32'b0000111);
		add_step(OP_JOY, 4'd0, 32'h80, 4'd0, 32'b0000100);
		add_step(OP_KEY, 4'd0, {key_release, `ARC_KEY_FIRE}, 4'd0, 32'b0000000);
		add_step(OP_WR, `ARC_REG_CTRL, 32'h0000_0002, 4'd1, 32'd0);
		add_step(OP_KEY, 4'd0, {key_press, `ARC_KEY_UP}, 4'd0, 32'b0010000);
		add_step(OP_JOY, 4'd0, 32'h08, 4'd0, 32'b1010000);
		add_step(OP_JOY, 4'd0, 32'h02, 4'd0, 32'b0011000);
		add_step(OP_KEY, 4'd0, {key_release, `ARC_KEY_UP}, 4'd0, 32'b0001000);
		add_step(OP_JOY, 4'd0, 32'h04, 4'd0, 32'b0100000);
		add_step(OP_JOY, 4'd0, 32'h50, 4'd0, 32'b0000101);
		add_step(OP_JOY, 4'd0, 32'h00, 4'd0, 32'b0000000);
		add_step(OP_WR, `ARC_REG_CTRL, 32'd0, 4'd0, 32'd0);
	endtask

	initial begin
		int                   i;
		int                   j;
		int                   lvl;
		logic [31:0]          rd;
		logic                 model_odd;
		logic                 prev_hs;
		logic                 prev_vs;
		arcade_pkg::vga_out_t exp_vga;
		reset    <= 1'b1;
		axil_req <= '0;
		dl       <= '0;
		key      <= '0;
		joystick <= 8'd0;
		pixel    <= '0;
		rom_addr <= '0;
		repeat (3) @(posedge clock_12);
		reset <= 1'b0;
		@(negedge clock_12);
		check_value("core_reset", 32'(core_reset), 32'd1);
		read_reg(`ARC_REG_STATUS, 0, rd);
		check_value("status", rd, 32'd0);

		rnd = 32'hdd70_0ac1;
		for (i = 0; i < 64; i++) begin
			rnd = next_random(rnd);
			rom_byte[i] = rnd[23:16];
			@(posedge clock_12);
			dl.active <= 1'b1;
			dl.wr     <= 1'b1;
			dl.addr   <= 12'(i * 65); // spread over the whole ROM.
			dl.data   <= rnd[23:16];
		end
		@(posedge clock_12);
		dl <= '0;
		@(posedge clock_12);
		@(negedge clock_12);
		check_value("core_reset", 32'(core_reset), 32'd1);
		@(posedge clock_12);
		@(negedge clock_12);
		check_value("core_reset", 32'(core_reset), 32'd0);
		read_reg(`ARC_REG_STATUS, 0, rd);
		check_value("status", rd, 32'd1);
		read_reg(`ARC_REG_COUNT, 0, rd);
		check_value("count", rd, 32'd64);

		for (i = 0; i <= 64; i++) begin
			@(posedge clock_12);
			if (i < 64) rom_addr <= 12'(i * 65);
			@(negedge clock_12);
			if (i > 0) check_value("rom_data", 32'(rom_data), 32'(rom_byte[i - 1]));
		end
		write_reg(`ARC_REG_CTRL, 32'd1, 0);
		@(negedge clock_12);
		check_value("core_reset", 32'(core_reset), 32'd1);
		write_reg(`ARC_REG_CTRL, 32'd0, 0);
		@(negedge clock_12);
		check_value("core_reset", 32'(core_reset), 32'd0);

		fill_steps();
		for (i = 0; i < steps.size(); i++) begin
			case (steps[i].op)
				OP_WR: write_reg(steps[i].addr, steps[i].data, int'(steps[i].hold));
				OP_RD: begin
					read_reg(steps[i].addr, int'(steps[i].hold), rd);
					check_value("rdata", rd, steps[i].exp);
				end
				OP_KEY: begin
					@(posedge clock_12);
					key.strobe  <= 1'b1;
					key.pressed <= steps[i].data[8];
					key.code    <= steps[i].data[7:0];
					@(posedge clock_12);
					key.strobe <= 1'b0;
					@(negedge clock_12);
					check_value("ctrl", 32'(ctrl), steps[i].exp);
				end
				default: begin
					@(posedge clock_12);
					joystick <= steps[i].data[7:0];
					@(posedge clock_12);
					@(negedge clock_12);
					check_value("ctrl", 32'(ctrl), steps[i].exp);
				end
			endcase
		end

		for (j = 0; j < 24; j++) begin
			rnd = next_random(rnd);
			pix[j].r      = rnd[31:29];
			pix[j].g      = rnd[28:26];
			pix[j].b      = rnd[25:24];
			pix[j].hs     = (j % 4 == 3);
			pix[j].vs     = (j == 0);
			pix[j].blankn = (j % 7 != 5);
		end
		model_odd = 1'b0;
		prev_hs   = 1'b0;
		prev_vs   = 1'b0;
		exp_vga   = '0;
		for (lvl = 0; lvl < 4; lvl++) begin
			write_reg(`ARC_REG_CTRL, 32'(lvl) << 2, 0);
			for (j = 0; j <= 24; j++) begin
				@(posedge clock_12);
				if (j < 24) pixel <= pix[j];
				@(negedge clock_12);
				if (j > 0) check_value("vga", 32'(vga), 32'(exp_vga));
				if (j < 24) begin
					exp_vga = expected_vga(pix[j], model_odd,
						arcade_pkg::scan_level_e'(lvl[1:0]));
					if (pix[j].vs && !prev_vs) model_odd = 1'b0;
					else if (pix[j].hs && !prev_hs) model_odd = !model_odd;
					prev_hs = pix[j].hs;
					prev_vs = pix[j].vs;
				end
			end
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: video_out.sv
`timescale 1ns/10ps
`default_nettype none

module video_out (
	input  logic                  clock_12,
	input  logic                  reset,
	input  arcade_pkg::cfg_t      cfg,
	input  arcade_pkg::pixel_in_t pixel,
	output arcade_pkg::vga_out_t  vga
);

	logic       hs_d;
	logic       vs_d;
	logic       line_odd;
	logic [2:0] b3;
	logic [5:0] r6;
	logic [5:0] g6;
	logic [5:0] b6;

	function automatic logic [5:0] dim(input logic [5:0] c, input arcade_pkg::scan_level_e lvl);
		case (lvl)
			arcade_pkg::SCAN_25: dim = c - (c >> 2);
			arcade_pkg::SCAN_50: dim = c >> 1;
			arcade_pkg::SCAN_75: dim = c >> 2;
			default:             dim = c;
		endcase
	endfunction

	always_comb begin
		b3 = {pixel.b, pixel.b[1]};
		r6 = {pixel.r, pixel.r};
		g6 = {pixel.g, pixel.g};
		b6 = {b3, b3};
	end

	always_ff @(posedge clock_12) begin
		if (reset) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_d <= pixel.hs;
			vs_d <= pixel.vs;
			if (pixel.vs && !vs_d) begin
				line_odd <= 1'b0; // each frame starts on an even line.
			end else if (pixel.hs && !hs_d) begin
				line_odd <= !line_odd;
			end
		end
	end

	always_ff @(posedge clock_12) begin
		if (reset) begin
			vga <= '0;
		end else begin
			vga.hs <= pixel.hs;
			vga.vs <= pixel.vs;
			if (!pixel.blankn) begin
				vga.r <= 6'd0;
				vga.g <= 6'd0;
				vga.b <= 6'd0;
			end else if (line_odd) begin
				vga.r <= dim(r6, cfg.scanlines);
				vga.g <= dim(g6, cfg.scanlines);
				vga.b <= dim(b6, cfg.scanlines);
			end else begin
				vga.r <= r6;
				vga.g <= g6;
				vga.b <= b6;
			end
		end
	end

endmodule

`default_nettype wire
